// ==== def.svh ====
`ifndef DEF_SVH
`define DEF_SVH

// side of the square feature map that layer 5 reads back
`define LAYER5_WIDTH 12
// one stored result word carries every channel of one position
`define LAYER4_OUTPUT_LENGTH 128
// channel count and raw accumulator width coming out of the conv engine
`define LAYER4_CHANNELS 8
`define LAYER4_ACC_WIDTH 24

`endif

// ==== cnn_pkg.sv ====
package cnn_pkg;

	`include "def.svh"

	// geometry of the layer 4 output map
	localparam int MAP_WIDTH = `LAYER5_WIDTH;
	localparam int MAP_SIZE = MAP_WIDTH * MAP_WIDTH;
	// row and col each fit in this many bits
	localparam int COORD_BITS = $clog2(MAP_WIDTH);
	// linear sram address width for the whole map
	localparam int ADDR_BITS = $clog2(MAP_SIZE);

	localparam int CHANNELS = `LAYER4_CHANNELS;
	localparam int ACC_BITS = `LAYER4_ACC_WIDTH;
	localparam int WORD_BITS = `LAYER4_OUTPUT_LENGTH;
	// each channel owns an equal slice of the result word
	localparam int FEAT_BITS = WORD_BITS / CHANNELS;

	typedef logic signed [ACC_BITS-1:0] acc_t;
	typedef logic [FEAT_BITS-1:0] feat_t;

	// all channel accumulators of one map position, channel 0 in the low bits
	typedef struct packed {
		acc_t [CHANNELS-1:0] ch;
	} acc_vec_t;

	// quantized features of one position, exactly one sram word
	typedef struct packed {
		feat_t [CHANNELS-1:0] ch;
	} feat_vec_t;

	// map coordinate as the later layer addresses it
	typedef struct packed {
		logic [COORD_BITS-1:0] row;
		logic [COORD_BITS-1:0] col;
	} map_addr_t;

endpackage

// ==== layer4_wrapper.sv ====
`timescale 1ns/1ps

module layer4_wrapper (
	input logic clk,
	input logic oeb,
	input logic wea,
	input logic [cnn_pkg::ADDR_BITS-1:0] a,
	input logic [cnn_pkg::ADDR_BITS-1:0] b,
	input logic [cnn_pkg::WORD_BITS-1:0] dia,
	output logic [cnn_pkg::WORD_BITS-1:0] dob
);

	// behavioral stand-in for the dual-port macro
	// port a is write only and port b is read only in this stage
	logic [cnn_pkg::WORD_BITS-1:0] mem [cnn_pkg::MAP_SIZE];

	// address decode that the real macro would do internally
	logic a_in_range;
	logic b_in_range;

	// addresses above the last word have no storage behind them
	assign a_in_range = int'(a) < cnn_pkg::MAP_SIZE;
	assign b_in_range = int'(b) < cnn_pkg::MAP_SIZE;

	// port a write
	// the word lands on the edge where wea is seen high
	always_ff @(posedge clk)
	begin
		if (wea && a_in_range)
		begin
			mem[a] <= dia;
		end
	end

	// port b read is registered so data shows up one cycle after oeb
	// with the output disabled the bus is driven to zero rather than held
	// a write and a read to the same word on one edge return the old word
	always_ff @(posedge clk)
	begin
		if (oeb && b_in_range)
		begin
			dob <= mem[b];
		end
		else
		begin
			dob <= '0;
		end
	end

endmodule

// ==== layer4_result_mem.sv ====
`timescale 1ns/1ps

module layer4_result_mem (
	input logic clk,
	input logic reset,
	input logic save_enable,
	input cnn_pkg::map_addr_t save_addr,
	input cnn_pkg::feat_vec_t data_in,
	input logic read_signal,
	input cnn_pkg::map_addr_t read_addr,
	output cnn_pkg::feat_vec_t result_output
);

	// linear word addresses for both sram ports
	logic [cnn_pkg::ADDR_BITS-1:0] save_addr_sram;
	logic [cnn_pkg::ADDR_BITS-1:0] read_addr_sram;
	// port strobes after the reset qualifier
	logic save_we;
	logic read_oe;

	// row times 12 is built as row times 16 minus row times 4
	// so no multiplier is needed for the map width
	function automatic logic [cnn_pkg::ADDR_BITS-1:0] linear_addr(
		input cnn_pkg::map_addr_t p
	);
		logic [cnn_pkg::ADDR_BITS-1:0] row_ext;
		logic [cnn_pkg::ADDR_BITS-1:0] col_ext;
		logic [cnn_pkg::ADDR_BITS-1:0] sum;
		row_ext = {{(cnn_pkg::ADDR_BITS - cnn_pkg::COORD_BITS){1'b0}}, p.row};
		col_ext = {{(cnn_pkg::ADDR_BITS - cnn_pkg::COORD_BITS){1'b0}}, p.col};
		sum = (row_ext << 4) - (row_ext << 2) + col_ext;
		// row 12 col 0 is where the counters sit once a frame is complete
		// fold it back onto word 0 so the address never leaves the array
		if (int'(sum) == cnn_pkg::MAP_SIZE)
		begin
			sum = '0;
		end
		return sum;
	endfunction

	assign save_addr_sram = linear_addr(save_addr);
	assign read_addr_sram = linear_addr(read_addr);

	// nothing is written and the read bus is forced to zero while reset is held
	assign save_we = save_enable & ~reset;
	assign read_oe = read_signal & ~reset;

	// port a carries writes and port b carries reads
	layer4_wrapper sram (
		.clk(clk),
		.oeb(read_oe),
		.wea(save_we),
		.a(save_addr_sram),
		.b(read_addr_sram),
		.dia(data_in),
		.dob(result_output)
	);

endmodule

// ==== layer4_activation.sv ====
`timescale 1ns/1ps

module layer4_activation #(
	// quantization shift with a legal range of 0 to 8
	parameter int SHIFT = 6
) (
	input logic clk,
	input logic reset,
	input logic acc_valid,
	input cnn_pkg::acc_vec_t acc_in,
	output logic feat_valid,
	output cnn_pkg::feat_vec_t feat
);

	// features for the position on the input this cycle
	cnn_pkg::feat_vec_t feat_next;

	// per channel relu, then the right shift, then the unsigned clamp
	// the sign bit alone decides relu so the shift only ever sees positive values
	always_comb
	begin
		logic [cnn_pkg::ACC_BITS-1:0] shifted;
		feat_next = '0;
		shifted = '0;
		for (int i = 0; i < cnn_pkg::CHANNELS; i++)
		begin
			shifted = acc_in.ch[i] >> SHIFT;
			if (acc_in.ch[i][cnn_pkg::ACC_BITS-1])
			begin
				feat_next.ch[i] = '0;
			end
			else if (|shifted[cnn_pkg::ACC_BITS-1:cnn_pkg::FEAT_BITS])
			begin
				// anything above 16 bits saturates to 65535
				feat_next.ch[i] = '1;
			end
			else
			begin
				feat_next.ch[i] = shifted[cnn_pkg::FEAT_BITS-1:0];
			end
		end
	end

	// the strobe follows acc_valid by one cycle and drops on reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			feat_valid <= 1'b0;
		end
		else
		begin
			feat_valid <= acc_valid;
		end
	end

	// the data register only loads on a valid position
	// so back-to-back strobes each see their own result
	always_ff @(posedge clk)
	begin
		if (acc_valid)
		begin
			feat <= feat_next;
		end
	end

endmodule

// ==== layer4_ctrl.sv ====
`timescale 1ns/1ps

module layer4_ctrl (
	input logic clk,
	input logic reset,
	input logic frame_start,
	input logic feat_valid,
	input logic rd_en,
	input cnn_pkg::map_addr_t rd_addr,
	output logic save_enable,
	output cnn_pkg::map_addr_t save_addr,
	output logic read_signal,
	output cnn_pkg::map_addr_t read_addr,
	output logic rd_valid,
	output logic frame_done,
	output logic busy
);

	// the written count has to reach the full map size and not just the last address
	localparam int COUNT_BITS = $clog2(cnn_pkg::MAP_SIZE + 1);

	// raster position of the next feature vector to store
	cnn_pkg::map_addr_t pos;
	// feature vectors stored in the open frame
	logic [COUNT_BITS-1:0] written;
	// the write taken this cycle completes the frame
	logic last_write;

	// a feature is stored only while a frame is open
	// strobes before frame_start or after the last position fall away here
	assign save_enable = feat_valid & busy;
	assign save_addr = pos;
	assign last_write = save_enable && (int'(written) == cnn_pkg::MAP_SIZE - 1);

	// reads go straight to the memory, which has its own output register
	assign read_signal = rd_en;
	assign read_addr = rd_addr;

	// raster counter walks col first and then row
	// after the final position it rests at row 12 col 0 until the next frame
	always_ff @(posedge clk)
	begin
		if (reset || frame_start)
		begin
			pos <= '0;
		end
		else if (save_enable)
		begin
			if (int'(pos.col) == cnn_pkg::MAP_WIDTH - 1)
			begin
				pos.col <= '0;
				pos.row <= pos.row + 1'b1;
			end
			else
			begin
				pos.col <= pos.col + 1'b1;
			end
		end
	end

	// the count of stored positions restarts with every frame
	always_ff @(posedge clk)
	begin
		if (reset || frame_start)
		begin
			written <= '0;
		end
		else if (save_enable)
		begin
			written <= written + 1'b1;
		end
	end

	// busy opens the frame on frame_start and closes it with the last write
	// frame_done is the registered last write so it is exactly one cycle wide
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			frame_done <= last_write;
			if (frame_start)
			begin
				busy <= 1'b1;
			end
			else if (last_write)
			begin
				busy <= 1'b0;
			end
		end
	end

	// rd_valid lines up with the registered sram output
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= rd_en;
		end
	end

endmodule

// ==== layer4_top.sv ====
`timescale 1ns/1ps

module layer4_top #(
	// quantization shift applied after relu, legal range 0 to 8
	parameter int SHIFT = 6
) (
	input logic clk,
	input logic reset,
	input logic frame_start,
	input logic acc_valid,
	input cnn_pkg::acc_vec_t acc_in,
	input logic rd_en,
	input cnn_pkg::map_addr_t rd_addr,
	output cnn_pkg::feat_vec_t rd_data,
	output logic rd_valid,
	output logic frame_done,
	output logic busy
);

	// activation result, one cycle behind the accumulator strobe
	logic feat_valid;
	cnn_pkg::feat_vec_t feat;
	// write side toward the result memory
	logic save_enable;
	cnn_pkg::map_addr_t save_addr;
	// read side toward the result memory
	logic read_signal;
	cnn_pkg::map_addr_t read_addr;

	// relu, shift and clamp of each incoming position
	layer4_activation #(
		.SHIFT(SHIFT)
	) activation (
		.clk(clk),
		.reset(reset),
		.acc_valid(acc_valid),
		.acc_in(acc_in),
		.feat_valid(feat_valid),
		.feat(feat)
	);

	// raster counting, write gating and frame status
	layer4_ctrl ctrl (
		.clk(clk),
		.reset(reset),
		.frame_start(frame_start),
		.feat_valid(feat_valid),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.save_enable(save_enable),
		.save_addr(save_addr),
		.read_signal(read_signal),
		.read_addr(read_addr),
		.rd_valid(rd_valid),
		.frame_done(frame_done),
		.busy(busy)
	);

	// the feature word is written in the same cycle that it leaves activation
	layer4_result_mem result_mem (
		.clk(clk),
		.reset(reset),
		.save_enable(save_enable),
		.save_addr(save_addr),
		.data_in(feat),
		.read_signal(read_signal),
		.read_addr(read_addr),
		.result_output(rd_data)
	);

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

// free running clock for the testbench, low at time zero
module tb_clock #(
	parameter int PERIOD_NS = 8
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	// one toggle every half period
	always
	begin
		#(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

// ==== layer4_assertions.sv ====
`timescale 1ns/1ps

module layer4_assertions (
	input logic clk,
	input logic reset,
	input logic frame_done,
	input logic rd_en,
	input logic rd_valid,
	input logic save_enable
);

	// frame_done marks one final write, so it never lasts two cycles
	property done_single_cycle;
		@(posedge clk) disable iff (reset)
		frame_done |=> !frame_done;
	endproperty

	// the valid flag is the read strobe one register later
	property valid_follows_read;
		@(posedge clk) disable iff (reset)
		!$past(reset) |-> (rd_valid == $past(rd_en));
	endproperty

	// no write may come out of a reset cycle
	property quiet_after_reset;
		@(posedge clk)
		reset |=> !save_enable;
	endproperty

	done_single_cycle_check: assert property (done_single_cycle)
		else $error("frame_done stayed high for two cycles");
	valid_follows_read_check: assert property (valid_follows_read)
		else $error("rd_valid does not match rd_en of the previous cycle");
	quiet_after_reset_check: assert property (quiet_after_reset)
		else $error("save_enable high right after reset");

endmodule

// ==== layer4_tb.sv ====
`timescale 1ns/1ps

module layer4_tb;

	localparam int SHIFT = 6;
	// cycle limits of the wait loops
	localparam int DONE_TIMEOUT = 400;
	localparam int READ_TIMEOUT = 8;

	typedef logic [cnn_pkg::COORD_BITS-1:0] coord_t;

	logic clk;
	logic reset;
	logic frame_start;
	logic acc_valid;
	cnn_pkg::acc_vec_t acc_in;
	logic rd_en;
	cnn_pkg::map_addr_t rd_addr;
	cnn_pkg::feat_vec_t rd_data;
	logic rd_valid;
	logic frame_done;
	logic busy;

	// expected result memory, indexed by raster position
	cnn_pkg::feat_vec_t model [cnn_pkg::MAP_SIZE];
	logic [31:0] lfsr_state = 32'h4453dfee;
	string cur_test;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_errors = 0;
	int done_count = 0;

	tb_clock #(
		.PERIOD_NS(8)
	) clock_gen (
		.clk(clk)
	);

	layer4_top #(
		.SHIFT(SHIFT)
	) DUT (
		.clk(clk),
		.reset(reset),
		.frame_start(frame_start),
		.acc_valid(acc_valid),
		.acc_in(acc_in),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.frame_done(frame_done),
		.busy(busy)
	);

	bind layer4_top layer4_assertions protocol_checks (
		.clk(clk),
		.reset(reset),
		.frame_done(frame_done),
		.rd_en(rd_en),
		.rd_valid(rd_valid),
		.save_enable(save_enable)
	);

	// each frame_done pulse is counted on the edge that ends it
	always @(posedge clk)
	begin
		if (frame_done)
			done_count <= done_count + 1;
	end

	// galois lfsr, stepped once for every bit handed out
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h80200003;
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	// corner values around relu, the shift and the 16 bit clamp for a shift of 6
	function automatic cnn_pkg::acc_t edge_value(input int k);
		case (k % 12)
			0: return 24'hffffff;
			1: return 24'h800000;
			2: return 24'h000000;
			3: return 24'h00003f;
			4: return 24'h000040;
			5: return 24'h00007f;
			6: return 24'h3fffc0;
			7: return 24'h3fffff;
			8: return 24'h400000;
			9: return 24'h7fffff;
			10: return 24'h3fff80;
			default: return 24'd12345;
		endcase
	endfunction

	function automatic cnn_pkg::acc_vec_t make_acc(input bit edges, input int p);
		cnn_pkg::acc_vec_t v;
		for (int c = 0; c < cnn_pkg::CHANNELS; c++)
			v.ch[c] = edges ? edge_value(p * cnn_pkg::CHANNELS + c) :
				cnn_pkg::acc_t'(rand_bits(cnn_pkg::ACC_BITS));
		return v;
	endfunction

	// model: negatives give zero, the rest is divided by 2**SHIFT and clamped
	function automatic cnn_pkg::feat_vec_t expected_feat(input cnn_pkg::acc_vec_t a);
		cnn_pkg::feat_vec_t f;
		int v;
		for (int c = 0; c < cnn_pkg::CHANNELS; c++)
		begin
			v = int'(a.ch[c]);
			v = (v < 0) ? 0 : v / (1 << SHIFT);
			f.ch[c] = (v > 65535) ? 16'hffff : 16'(v);
		end
		return f;
	endfunction

	function automatic cnn_pkg::map_addr_t position(input int p);
		cnn_pkg::map_addr_t a;
		a.row = coord_t'(p / cnn_pkg::MAP_WIDTH);
		a.col = coord_t'(p % cnn_pkg::MAP_WIDTH);
		return a;
	endfunction

	task automatic check_value(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what,
				expected, actual);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("TIMEOUT in %s: %s", cur_test, what);
		errors++;
	endtask

	task automatic wait_frame_done();
		int cycles;
		cycles = 0;
		while (!frame_done && cycles < DONE_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		// busy drops on the same edge that raises frame_done
		if (!frame_done)
			report_timeout("frame_done never pulsed");
		else
			check_value("busy at frame_done", 128'(0), 128'(busy));
	endtask

	// one read, the strobe is held for a single cycle
	task automatic read_word(input cnn_pkg::map_addr_t a, output cnn_pkg::feat_vec_t d);
		int cycles;
		rd_en = 1'b1;
		rd_addr = a;
		@(negedge clk);
		rd_en = 1'b0;
		cycles = 1;
		while (!rd_valid && cycles < READ_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!rd_valid)
			report_timeout("rd_valid never rose after a read");
		else
			check_value("read latency", 128'(1), 128'(cycles));
		d = rd_data;
	endtask

	// opens a frame and streams all positions, with random idle gaps if asked
	task automatic send_frame(input bit edges, input bit gaps);
		cnn_pkg::acc_vec_t v;
		int idle;
		frame_start = 1'b1;
		@(negedge clk);
		frame_start = 1'b0;
		for (int p = 0; p < cnn_pkg::MAP_SIZE; p++)
		begin
			v = make_acc(edges, p);
			model[p] = expected_feat(v);
			acc_valid = 1'b1;
			acc_in = v;
			@(negedge clk);
			acc_valid = 1'b0;
			check_value("busy in frame", 128'(1), 128'(busy));
			idle = (gaps && p < cnn_pkg::MAP_SIZE - 1) ? int'(rand_bits(2)) : 0;
			for (int i = 0; i < idle; i++)
			begin
				@(negedge clk);
				check_value("busy in gap", 128'(1), 128'(busy));
			end
		end
		wait_frame_done();
	endtask

	task automatic check_frame();
		cnn_pkg::feat_vec_t d;
		for (int p = 0; p < cnn_pkg::MAP_SIZE; p++)
		begin
			read_word(position(p), d);
			check_value($sformatf("word %0d", p), model[p], d);
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = errors;
		tests++;
	endtask

	task automatic finish_test();
		$display("test %s finished with %0d errors", cur_test, errors - test_errors);
	endtask

	task automatic test_reset_state();
		cnn_pkg::feat_vec_t d;
		start_test("reset_state");
		check_value("frame_done", 128'(0), 128'(frame_done));
		check_value("busy", 128'(0), 128'(busy));
		check_value("rd_valid", 128'(0), 128'(rd_valid));
		// the memory is still unwritten, only the latency matters here
		read_word(position(0), d);
		finish_test();
	endtask

	task automatic test_full_frame();
		int done_before;
		start_test("full_frame");
		done_before = done_count;
		send_frame(1'b0, 1'b0);
		repeat (4) @(negedge clk);
		check_value("frame_done pulses", 128'(1), 128'(done_count - done_before));
		check_frame();
		finish_test();
	endtask

	task automatic test_activation_edges();
		start_test("activation_edges");
		send_frame(1'b1, 1'b0);
		check_frame();
		finish_test();
	endtask

	task automatic test_gapped_extras();
		int done_before;
		start_test("gapped_extras");
		done_before = done_count;
		send_frame(1'b0, 1'b1);
		// strobes past the last position with no frame open
		for (int i = 0; i < 6; i++)
		begin
			acc_valid = 1'b1;
			acc_in = make_acc(1'b0, i);
			@(negedge clk);
		end
		acc_valid = 1'b0;
		repeat (4) @(negedge clk);
		check_value("busy after extras", 128'(0), 128'(busy));
		check_value("frame_done pulses", 128'(1), 128'(done_count - done_before));
		check_frame();
		finish_test();
	endtask

	task automatic test_new_frame();
		start_test("new_frame");
		send_frame(1'b0, 1'b0);
		check_frame();
		finish_test();
	endtask

	task automatic test_idle_read();
		cnn_pkg::feat_vec_t d;
		start_test("idle_read");
		read_word(position(cnn_pkg::MAP_SIZE - 1), d);
		check_value("last word", model[cnn_pkg::MAP_SIZE - 1], d);
		for (int i = 0; i < 16; i++)
		begin
			@(negedge clk);
			check_value("idle rd_valid", 128'(0), 128'(rd_valid));
			check_value("idle rd_data", 128'(0), rd_data);
		end
		finish_test();
	endtask

	initial
	begin
		reset = 1'b1;
		frame_start = 1'b0;
		acc_valid = 1'b0;
		acc_in = '0;
		rd_en = 1'b0;
		rd_addr = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		test_reset_state();
		test_full_frame();
		test_activation_edges();
		test_gapped_extras();
		test_new_frame();
		test_idle_read();
		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+.
cnn_pkg.sv
layer4_wrapper.sv
layer4_result_mem.sv
layer4_activation.sv
layer4_ctrl.sv
layer4_top.sv
tb_clock.sv
layer4_assertions.sv
layer4_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module layer4_tb -o layer4_sim &&
./obj_dir/layer4_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
